// File: decode_pkg.sv
// Decode stage shared encodings, busy latencies and record types
package decode_pkg;

	// ================================================
	// Widths and latencies
	// ================================================

	// EXI payload width, taken from the instruction bits above the opcode
	localparam int unsigned PREFIX_W = 25;

	typedef logic [3:0] busy_cnt_t;

	// Busy cycles per operation class
	localparam busy_cnt_t LAT_MUL = 4'd3;
	localparam busy_cnt_t LAT_DIV = 4'd8;
	localparam busy_cnt_t LAT_MEM = 4'd2;

	// ================================================
	// Encodings
	// ================================================

	typedef enum logic [6:0] {
		OP_R3   = 7'h02,
		OP_ADDI = 7'h04,
		OP_MULI = 7'h06,
		OP_DIVI = 7'h07,
		OP_LDB  = 7'h50,
		OP_LDBU = 7'h51,
		OP_LDW  = 7'h52,
		OP_LDT  = 7'h54,
		OP_LDO  = 7'h56,
		OP_STB  = 7'h60,
		OP_STW  = 7'h61,
		OP_STO  = 7'h63,
		OP_EXI  = 7'h7e
	} opcode_e;

	// Only the low 32 values fit the 5-bit field of the R3 format
	typedef enum logic [5:0] {
		F_ADD  = 6'h04,
		F_SUB  = 6'h05,
		F_AND  = 6'h08,
		F_MUL  = 6'h10,
		F_MULU = 6'h11,
		F_DIV  = 6'h14,
		F_DIVU = 6'h15
	} func_e;

	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} memsz_e;

	// ================================================
	// Instruction word and decode record
	// ================================================

	// Opcode sits in bits 6:0 in both views
	typedef struct packed {
		logic [4:0] func;
		logic [4:0] rc;
		logic [4:0] rb;
		logic [4:0] ra;
		logic [4:0] rt;
		logic [6:0] opcode;
	} insn_r3_t;

	typedef struct packed {
		logic [14:0] imm;
		logic [4:0]  ra;
		logic [4:0]  rt;
		logic [6:0]  opcode;
	} insn_ri_t;

	typedef union packed {
		insn_r3_t r3;
		insn_ri_t ri;
	} insn_t;

	typedef struct packed {
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [4:0]  rc;
		logic [63:0] imm;
		logic        rfwr;
		logic        is_ld;
		logic        ldz;
		logic        is_st;
		logic        mul;
		logic        mulu;
		logic        div;
		logic        divu;
		logic        illegal;
		memsz_e      memsz;
	} dec_out_t;

endpackage

// File: insn_decoder.sv
// Instruction decoder from one word and a pending EXI prefix to a control record
`timescale 1ns/1ps

module insn_decoder (
	input  decode_pkg::insn_t               insn,
	input  logic                            pfx_valid,
	input  logic [decode_pkg::PREFIX_W-1:0] pfx_payload,
	output decode_pkg::dec_out_t            dec_next,
	output decode_pkg::busy_cnt_t           busy_cycles,
	output logic                            is_prefix
);
	import decode_pkg::*;

	logic legal;
	logic is_ri;

	always_comb
	begin
		dec_next       = '0;
		dec_next.rt    = insn.ri.rt;
		dec_next.ra    = insn.ri.ra;
		dec_next.memsz = SZ_OCTA;
		legal          = 1'b1;
		is_ri          = 1'b0;
		is_prefix      = 1'b0;

		// ================================================
		// Opcode class
		// ================================================
		case (insn.ri.opcode)
		OP_R3:
		begin
			dec_next.rb = insn.r3.rb;
			dec_next.rc = insn.r3.rc;
			case ({1'b0, insn.r3.func})
			F_ADD, F_SUB, F_AND:	;
			F_MUL:	dec_next.mul = 1'b1;
			F_MULU:	dec_next.mulu = 1'b1;
			F_DIV:	dec_next.div = 1'b1;
			F_DIVU:	dec_next.divu = 1'b1;
			default:	legal = 1'b0;
			endcase
		end
		OP_ADDI:	is_ri = 1'b1;
		OP_MULI:
		begin
			is_ri        = 1'b1;
			dec_next.mul = 1'b1;
		end
		OP_DIVI:
		begin
			is_ri        = 1'b1;
			dec_next.div = 1'b1;
		end
		OP_LDB, OP_LDBU, OP_LDW, OP_LDT, OP_LDO:
		begin
			is_ri          = 1'b1;
			dec_next.is_ld = 1'b1;
			dec_next.ldz   = (insn.ri.opcode == OP_LDBU);
		end
		OP_STB, OP_STW, OP_STO:
		begin
			is_ri          = 1'b1;
			dec_next.is_st = 1'b1;
		end
		OP_EXI:	is_prefix = 1'b1;
		default:	legal = 1'b0;
		endcase

		// Access size from the opcode letter
		case (insn.ri.opcode)
		OP_LDB, OP_LDBU, OP_STB:	dec_next.memsz = SZ_BYTE;
		OP_LDW, OP_STW:	dec_next.memsz = SZ_WYDE;
		OP_LDT:	dec_next.memsz = SZ_TETRA;
		default:	dec_next.memsz = SZ_OCTA;
		endcase

		dec_next.illegal = ~legal;

		// ================================================
		// Immediate and write enable
		// ================================================
		// A pending EXI supplies bits 39:15, sign extended from bit 39
		if (is_ri)
		begin
			if (pfx_valid)
				dec_next.imm = {{(64 - PREFIX_W - 15){pfx_payload[PREFIX_W-1]}},
					pfx_payload, insn.ri.imm};
			else
				dec_next.imm = {{49{insn.ri.imm[14]}}, insn.ri.imm};
		end

		// r0 is never written
		dec_next.rfwr = legal && !is_prefix && !dec_next.is_st && (insn.ri.rt != 5'd0);

		// Multi-cycle hold time
		if (dec_next.mul || dec_next.mulu)
			busy_cycles = LAT_MUL;
		else if (dec_next.div || dec_next.divu)
			busy_cycles = LAT_DIV;
		else if (dec_next.is_ld || dec_next.is_st)
			busy_cycles = LAT_MEM;
		else
			busy_cycles = '0;
	end

endmodule

// File: imm_prefix.sv
// EXI prefix register holding the upper immediate bits for the next instruction
`timescale 1ns/1ps

module imm_prefix (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            accept,
	input  logic                            is_prefix,
	input  logic [decode_pkg::PREFIX_W-1:0] payload_in,
	output logic                            pfx_valid,
	output logic [decode_pkg::PREFIX_W-1:0] pfx_payload
);

	// Any accepted non-prefix instruction consumes the pending payload
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pfx_valid <= 1'b0;
		else if (accept)
			pfx_valid <= is_prefix;
	end

	// A second EXI simply overwrites the first
	always_ff @(posedge clk)
	begin
		if (accept && is_prefix)
			pfx_payload <= payload_in;
	end

endmodule

// File: busy_timer.sv
// Loadable down-counter timing multi-cycle operations
`timescale 1ns/1ps

module busy_timer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  decode_pkg::busy_cnt_t load_value,
	output logic                  busy,
	output logic                  done
);
	import decode_pkg::*;

	busy_cnt_t count;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			count <= '0;
		else if (start)
			count <= load_value;
		else if (count != '0)
			count <= count - 1'b1;
	end

	// Busy for load_value cycles after the start edge
	assign busy = (count != '0);

	// Last busy cycle, counter hits zero on the next edge
	assign done = (count == busy_cnt_t'(1));

endmodule

// File: issue_fsm.sv
// Issue control that accepts instructions, registers the record and holds off while busy
`timescale 1ns/1ps

module issue_fsm (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  insn_valid,
	input  logic                  is_prefix,
	input  decode_pkg::dec_out_t  dec_next,
	input  decode_pkg::busy_cnt_t busy_cycles,
	input  logic                  busy,
	input  logic                  done,
	output logic                  accept,
	output logic                  start,
	output logic                  insn_ready,
	output logic                  dec_valid,
	output decode_pkg::dec_out_t  dec
);

	typedef enum logic {
		IDLE,
		WAIT
	} state_e;

	state_e state;
	state_e state_nxt;
	logic   issue;

	assign insn_ready = (state == IDLE);
	assign accept     = insn_valid && insn_ready;

	// Prefixes only load the prefix register
	assign issue = accept && !is_prefix;
	assign start = issue && (busy_cycles != '0);

	always_comb
	begin
		state_nxt = state;
		case (state)
		IDLE:
			if (start)
				state_nxt = WAIT;
		WAIT:
			// Timer's last busy cycle ends the wait
			if (done)
				state_nxt = IDLE;
		default:
			state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= IDLE;
			dec_valid <= 1'b0;
			dec       <= '0;
		end
		else
		begin
			state     <= state_nxt;
			dec_valid <= issue;
			if (issue)
				dec <= dec_next;
		end
	end

endmodule

// File: decode_stage.sv
// Decode stage top joining decoder, prefix register, busy timer and issue control
`timescale 1ns/1ps

module decode_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 insn_valid,
	input  decode_pkg::insn_t    insn,
	output logic                 insn_ready,
	output logic                 dec_valid,
	output decode_pkg::dec_out_t dec
);
	import decode_pkg::*;

	logic                pfx_valid;
	logic [PREFIX_W-1:0] pfx_payload;
	dec_out_t            dec_next;
	busy_cnt_t           busy_cycles;
	logic                is_prefix;
	logic                accept;
	logic                start;
	logic                busy;
	logic                done;

	insn_decoder u_decoder (
		.insn        (insn),
		.pfx_valid   (pfx_valid),
		.pfx_payload (pfx_payload),
		.dec_next    (dec_next),
		.busy_cycles (busy_cycles),
		.is_prefix   (is_prefix)
	);

	// EXI payload is everything above the opcode
	imm_prefix u_prefix (
		.clk         (clk),
		.rst_n       (rst_n),
		.accept      (accept),
		.is_prefix   (is_prefix),
		.payload_in  (insn[31 -: PREFIX_W]),
		.pfx_valid   (pfx_valid),
		.pfx_payload (pfx_payload)
	);

	busy_timer u_timer (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.load_value (busy_cycles),
		.busy       (busy),
		.done       (done)
	);

	issue_fsm u_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.insn_valid  (insn_valid),
		.is_prefix   (is_prefix),
		.dec_next    (dec_next),
		.busy_cycles (busy_cycles),
		.busy        (busy),
		.done        (done),
		.accept      (accept),
		.start       (start),
		.insn_ready  (insn_ready),
		.dec_valid   (dec_valid),
		.dec         (dec)
	);

endmodule

// File: tb_clock_gen.sv
// Testbench clock and power-on reset source
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int PERIOD_NS    = 20;
	localparam int RESET_CYCLES = 4;

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2) clk = ~clk;
	end

	// Release lands just after an edge, clear of the sampling point
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

// File: decode_stage_props.sv
// Concurrent assertions on the decode stage handshake and output record
`timescale 1ns/1ps

module decode_stage_props (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 accept,
	input logic                 insn_ready,
	input logic                 dec_valid,
	input decode_pkg::dec_out_t dec
);

	int assert_fails = 0;

	// Stage leaves reset ready and with no record pending
	reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> (insn_ready && !dec_valid))
	else
	begin
		assert_fails++;
		$error("insn_ready low or dec_valid high right after reset");
	end

	// Every output pulse comes from an accept one cycle earlier
	valid_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
		dec_valid |-> $past(accept))
	else
	begin
		assert_fails++;
		$error("dec_valid high without an accept in the previous cycle");
	end

	load_store_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dec.is_ld && dec.is_st))
	else
	begin
		assert_fails++;
		$error("record has both is_ld and is_st set");
	end

endmodule

// File: decode_stage_checker.sv
// Testbench monitor comparing decode records and busy windows with a reference model
`timescale 1ns/1ps

module decode_stage_checker (
	input  logic                 clk,
	input  logic                 rst_n,
	input  int                   test_id,
	input  logic                 insn_valid,
	input  decode_pkg::insn_t    insn,
	input  logic                 insn_ready,
	input  logic                 dec_valid,
	input  decode_pkg::dec_out_t dec,
	output int                   pass_cnt,
	output int                   fail_cnt,
	output int                   pending
);
	import decode_pkg::*;

	// One accepted non-prefix instruction and the prefix it saw
	typedef struct packed {
		insn_t               word;
		logic                pfx_valid;
		logic [PREFIX_W-1:0] pfx_payload;
	} issued_t;

	issued_t             issued_q[$];
	issued_t             entry;
	dec_out_t            expected;
	logic                pfx_valid;
	logic [PREFIX_W-1:0] pfx_payload;
	busy_cnt_t           busy_expect;
	int                  busy_seen;
	logic                busy_open;
	int                  last_id;
	int                  test_pass;
	int                  test_fail;

	function automatic string test_label(input int id);
		case (id)
		1:	return "alu_fields";
		2:	return "load_store";
		3:	return "prefix_imm";
		4:	return "mul_div";
		5:	return "busy_timing";
		6:	return "illegal";
		default:	return "idle";
		endcase
	endfunction

	// ================================================
	// Reference decode model
	// ================================================
	function automatic dec_out_t ref_decode(input insn_t w, input logic pv,
		input logic [PREFIX_W-1:0] pp);
		dec_out_t   d;
		logic [6:0] op;
		logic [5:0] fn;
		logic       known;
		op      = w.r3.opcode;
		fn      = {1'b0, w.r3.func};
		d       = '0;
		d.rt    = w.r3.rt;
		d.ra    = w.r3.ra;
		d.is_ld = (op == OP_LDB) || (op == OP_LDBU) || (op == OP_LDW) ||
			(op == OP_LDT) || (op == OP_LDO);
		d.ldz   = (op == OP_LDBU);
		d.is_st = (op == OP_STB) || (op == OP_STW) || (op == OP_STO);
		// Size letter B, W, T or O; everything else counts as octa
		d.memsz = SZ_OCTA;
		if ((op == OP_LDB) || (op == OP_LDBU) || (op == OP_STB))
			d.memsz = SZ_BYTE;
		if ((op == OP_LDW) || (op == OP_STW))
			d.memsz = SZ_WYDE;
		if (op == OP_LDT)
			d.memsz = SZ_TETRA;
		if (op == OP_R3)
		begin
			d.rb   = w.r3.rb;
			d.rc   = w.r3.rc;
			d.mul  = (fn == F_MUL);
			d.mulu = (fn == F_MULU);
			d.div  = (fn == F_DIV);
			d.divu = (fn == F_DIVU);
			known  = (fn == F_ADD) || (fn == F_SUB) || (fn == F_AND) ||
				d.mul || d.mulu || d.div || d.divu;
		end
		else
		begin
			d.mul = (op == OP_MULI);
			d.div = (op == OP_DIVI);
			known = d.is_ld || d.is_st || d.mul || d.div || (op == OP_ADDI);
			if (known && pv)
				d.imm = {{24{pp[PREFIX_W-1]}}, pp, w.ri.imm};
			else if (known)
				d.imm = {{49{w.ri.imm[14]}}, w.ri.imm};
		end
		d.illegal = !known;
		d.rfwr    = known && !d.is_st && (d.rt != 5'd0);
		return d;
	endfunction

	function automatic busy_cnt_t ref_busy(input dec_out_t d);
		if (d.mul || d.mulu)
			return LAT_MUL;
		if (d.div || d.divu)
			return LAT_DIV;
		if (d.is_ld || d.is_st)
			return LAT_MEM;
		return '0;
	endfunction

	task automatic note_result(input logic ok);
		if (ok)
		begin
			pass_cnt++;
			test_pass++;
		end
		else
		begin
			fail_cnt++;
			test_fail++;
		end
	endtask

	// ================================================
	// Port monitor, sampled mid-cycle
	// ================================================
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			issued_q.delete();
			pfx_valid   = 1'b0;
			pfx_payload = '0;
			busy_open   = 1'b0;
			last_id     = test_id;
		end
		else
		begin
			if (test_id != last_id)
			begin
				if (last_id != 0)
					$display("Test %0s done: %0d checks passed, %0d failed",
						test_label(last_id), test_pass, test_fail);
				test_pass = 0;
				test_fail = 0;
				last_id   = test_id;
			end

			if (dec_valid && (issued_q.size() == 0))
			begin
				$display("Error in %0s: dec_valid pulsed with no accepted instruction waiting",
					test_label(last_id));
				note_result(1'b0);
			end
			else if (dec_valid)
			begin
				entry    = issued_q.pop_front();
				expected = ref_decode(entry.word, entry.pfx_valid, entry.pfx_payload);
				if (dec !== expected)
					$display("Fail %0s: expected %h, actual %h", test_label(last_id),
						expected, dec);
				note_result(dec === expected);
			end

			// Ready stays low for the whole busy window, then rises
			if (busy_open && !insn_ready)
				busy_seen++;
			else if (busy_open)
			begin
				busy_open = 1'b0;
				if (busy_seen != int'(busy_expect))
					$display("Fail %0s busy cycles: expected %0d, actual %0d",
						test_label(last_id), busy_expect, busy_seen);
				note_result(busy_seen == int'(busy_expect));
			end

			// Accept at the coming edge
			if (insn_valid && insn_ready)
			begin
				busy_expect = '0;
				if (insn.ri.opcode == OP_EXI)
				begin
					pfx_valid   = 1'b1;
					pfx_payload = insn[31 -: PREFIX_W];
				end
				else
				begin
					entry.word        = insn;
					entry.pfx_valid   = pfx_valid;
					entry.pfx_payload = pfx_payload;
					issued_q.push_back(entry);
					busy_expect = ref_busy(ref_decode(insn, pfx_valid, pfx_payload));
					pfx_valid   = 1'b0;
				end
				busy_seen = 0;
				busy_open = 1'b1;
			end
		end
		pending = issued_q.size();
	end

endmodule

// File: decode_stage_tb.sv
// Testbench top driving the decode stage through each instruction class
`timescale 1ns/1ps

module decode_stage_tb;
	import decode_pkg::*;

	localparam int N_INSN      = 89;
	localparam int CLK_NS      = 20;
	localparam int DRIVE_NS    = 2;
	localparam int WATCHDOG_NS = (N_INSN * (int'(LAT_DIV) + 2) + 4) * CLK_NS;

	logic     clk;
	logic     rst_n;
	logic     insn_valid;
	insn_t    insn;
	logic     insn_ready;
	logic     dec_valid;
	dec_out_t dec;
	int       test_id;
	int       pass_cnt;
	int       fail_cnt;
	int       pending;
	int       seed;
	opcode_e  mem_ops [8] = '{OP_LDB, OP_LDBU, OP_LDW, OP_LDT, OP_LDO, OP_STB, OP_STW, OP_STO};

	tb_clock_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	decode_stage DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.insn_valid (insn_valid),
		.insn       (insn),
		.insn_ready (insn_ready),
		.dec_valid  (dec_valid),
		.dec        (dec)
	);

	decode_stage_checker u_checker (
		.clk        (clk),
		.rst_n      (rst_n),
		.test_id    (test_id),
		.insn_valid (insn_valid),
		.insn       (insn),
		.insn_ready (insn_ready),
		.dec_valid  (dec_valid),
		.dec        (dec),
		.pass_cnt   (pass_cnt),
		.fail_cnt   (fail_cnt),
		.pending    (pending)
	);

	bind decode_stage decode_stage_props u_props (
		.clk        (clk),
		.rst_n      (rst_n),
		.accept     (accept),
		.insn_ready (insn_ready),
		.dec_valid  (dec_valid),
		.dec        (dec)
	);

	// ================================================
	// Stimulus helpers
	// ================================================
	function automatic insn_t r3_word(input func_e f);
		insn_t w;
		w           = insn_t'($random(seed));
		w.r3.opcode = OP_R3;
		w.r3.func   = f[4:0];
		return w;
	endfunction

	function automatic insn_t ri_word(input opcode_e op);
		insn_t w;
		w           = insn_t'($random(seed));
		w.ri.opcode = op;
		return w;
	endfunction

	// Holds the word until the DUT takes it
	task automatic send(input insn_t w);
		while (!insn_ready)
		begin
			@(posedge clk);
			#(DRIVE_NS);
		end
		insn_valid = 1'b1;
		insn       = w;
		@(posedge clk);
		#(DRIVE_NS);
		insn_valid = 1'b0;
	endtask

	task automatic drain();
		while (!insn_ready)
		begin
			@(posedge clk);
			#(DRIVE_NS);
		end
		repeat (2) @(posedge clk);
		#(DRIVE_NS);
	endtask

	// ================================================
	// Test sequence
	// ================================================
	initial
	begin
		insn_t w;
		int    k;
		insn_valid = 1'b0;
		insn       = '0;
		test_id    = 0;
		seed       = 32'hb7dce9d6;
		@(posedge rst_n);
		@(posedge clk);
		#(DRIVE_NS);

		test_id = 1;
		w       = ri_word(OP_ADDI);
		w.ri.rt = 5'd0;
		send(w);
		w       = r3_word(F_SUB);
		w.r3.rt = 5'd0;
		send(w);
		repeat (20)
		begin
			k = {$random(seed)} % 4;
			case (k)
			0:	w = r3_word(F_ADD);
			1:	w = r3_word(F_SUB);
			2:	w = r3_word(F_AND);
			default:	w = ri_word(OP_ADDI);
			endcase
			send(w);
		end
		drain();

		test_id = 2;
		foreach (mem_ops[i])
		begin
			send(ri_word(mem_ops[i]));
			send(ri_word(mem_ops[i]));
		end
		drain();

		// Second EXI overrides, R3 consumes the prefix with a zero immediate
		test_id = 3;
		send(ri_word(OP_EXI));
		send(ri_word(OP_ADDI));
		send(ri_word(OP_EXI));
		send(ri_word(OP_EXI));
		send(ri_word(OP_ADDI));
		send(ri_word(OP_ADDI));
		send(ri_word(OP_EXI));
		send(r3_word(F_ADD));
		send(ri_word(OP_ADDI));
		send(ri_word(OP_EXI));
		send(ri_word(OP_LDO));
		drain();

		test_id = 4;
		repeat (2)
		begin
			send(r3_word(F_MUL));
			send(r3_word(F_MULU));
			send(r3_word(F_DIV));
			send(r3_word(F_DIVU));
			send(ri_word(OP_MULI));
			send(ri_word(OP_DIVI));
		end
		drain();

		test_id = 5;
		repeat (12)
		begin
			k = {$random(seed)} % 5;
			case (k)
			0:	w = r3_word(F_MUL);
			1:	w = r3_word(F_DIVU);
			2:	w = ri_word(OP_MULI);
			3:	w = ri_word(OP_DIVI);
			default:	w = ri_word(mem_ops[{$random(seed)} % 8]);
			endcase
			send(w);
		end
		drain();

		// Opcodes 08..47 and functions 18..1f are unassigned
		test_id = 6;
		repeat (8)
		begin
			w           = ri_word(OP_ADDI);
			w.ri.opcode = 7'h08 + 7'({$random(seed)} % 64);
			send(w);
			w         = r3_word(F_ADD);
			w.r3.func = 5'h18 + 5'({$random(seed)} % 8);
			send(w);
		end
		drain();

		test_id = 0;
		repeat (2) @(negedge clk);
		if (pending != 0)
			$display("Error: %0d accepted instructions never produced dec_valid", pending);
		$display("Summary: %0d checks passed, %0d failed, %0d assertion failures",
			pass_cnt, fail_cnt, DUT.u_props.assert_fails);
		if ((fail_cnt == 0) && (pending == 0) && (DUT.u_props.assert_fails == 0))
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: vlog.f
decode_pkg.sv
insn_decoder.sv
imm_prefix.sv
busy_timer.sv
issue_fsm.sv
decode_stage.sv
tb_clock_gen.sv
decode_stage_props.sv
decode_stage_checker.sv
decode_stage_tb.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - insn_decoder.sv
  - imm_prefix.sv
  - busy_timer.sv
  - issue_fsm.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - decode_stage_props.sv
      - decode_stage_checker.sv
      - decode_stage_tb.sv
